// File: include/arb_macros.svh
`ifndef ARB_MACROS_SVH
`define ARB_MACROS_SVH

//////////////////////////////
// crossbar geometry
//////////////////////////////

`define ARB_PORTS 8 // sources and destinations

`define ARB_DEPTH 8 // entries per source buffer

`define ARB_DEST_W 4 // one destination code

// code left in a slot that holds no connection
`define ARB_NO_CONN 4'hF

`endif

// File: verilog/arb_pkg.sv
`default_nettype none

`include "arb_macros.svh"

package arb_pkg;

   typedef logic [`ARB_DEST_W-1:0] dest_t; // one destination code
   typedef logic [$clog2(`ARB_PORTS)-1:0] port_idx_t; // port, slot or pointer

   typedef logic [`ARB_PORTS-1:0] neuron_mask_t; // bit 7 is port 0
   typedef logic [`ARB_PORTS*`ARB_DEST_W-1:0] port_map_t; // port 0 in top nibble

   // port 0 owns the top word, slot 0 the top nibble of each word
   typedef logic [`ARB_PORTS*`ARB_DEPTH*`ARB_DEST_W-1:0] network_t;

   typedef enum logic [2:0] {
      ARB_IDLE, // nothing pending
      ARB_SCAN, // reload buffers of pending neurons
      ARB_MATCH, // matcher walks the destinations
      ARB_XMIT, // map offered, waiting for drdy
      ARB_ACK // srdy high until drdy drops
   } arb_state_t;

endpackage

`default_nettype wire

// File: verilog/arb_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface arb_ctrl_if;
   import arb_pkg::*;

   logic load; // reload strobe
   neuron_mask_t load_mask; // which buffers reload
   logic all_empty; // every entry is no-connection
   logic match_start; // kick off one matching round
   port_idx_t bias; // first source searched
   logic match_done; // round finished, map updated

   modport seq (
      output load, load_mask, match_start, bias,
      input all_empty, match_done
   );

   modport bank (
      input load, load_mask,
      output all_empty
   );

   modport matcher (
      input match_start, bias,
      output match_done
   );

endinterface

`default_nettype wire

// File: verilog/arb_buf_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "arb_macros.svh"

interface arb_buf_if;
   import arb_pkg::*;

   dest_t entries [`ARB_PORTS][`ARB_DEPTH]; // [source][slot]
   port_idx_t ptrs [`ARB_PORTS]; // per-source read pointer

   logic clr; // grant strobe
   port_idx_t clr_src; // granted source
   port_idx_t clr_slot; // granted slot

   modport bank (output entries, ptrs, input clr, clr_src, clr_slot);

   modport matcher (input entries, ptrs, output clr, clr_src, clr_slot);

endinterface

`default_nettype wire

// File: verilog/dest_buffer_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "arb_macros.svh"

module dest_buffer_bank (
   input logic cur_state,
   input logic arst_n,
   input arb_pkg::network_t network,
   arb_ctrl_if.bank ctrl,
   arb_buf_if.bank buf_io
);
   import arb_pkg::*;

   localparam int NET_W = $bits(network_t);

   dest_t entry_q [`ARB_PORTS][`ARB_DEPTH];
   port_idx_t ptr_q [`ARB_PORTS];
   logic empty;

   //////////////////////////////
   // buffers and pointers
   //////////////////////////////

   always_ff @(posedge cur_state or negedge arst_n) begin
      if (!arst_n) begin
         for (int p = 0; p < `ARB_PORTS; p++) begin
            ptr_q[p] <= '0;
            for (int s = 0; s < `ARB_DEPTH; s++) begin
               entry_q[p][s] <= `ARB_NO_CONN;
            end
         end
      end else if (ctrl.load) begin
         for (int p = 0; p < `ARB_PORTS; p++) begin
            if (ctrl.load_mask[`ARB_PORTS-1-p]) begin // mask msb is port 0
               for (int s = 0; s < `ARB_DEPTH; s++) begin
                  entry_q[p][s] <= network[NET_W-1-(p*`ARB_DEPTH+s)*`ARB_DEST_W -: `ARB_DEST_W];
               end
            end
         end
      end else if (buf_io.clr) begin
         entry_q[buf_io.clr_src][buf_io.clr_slot] <= `ARB_NO_CONN; // grant consumed
         ptr_q[buf_io.clr_src] <= port_idx_t'(buf_io.clr_slot + 1'b1); // wraps at 8
      end
   end

   assign buf_io.entries = entry_q;
   assign buf_io.ptrs = ptr_q;

   //////////////////////////////
   // empty detect
   //////////////////////////////

   always_comb begin
      empty = 1'b1;
      for (int p = 0; p < `ARB_PORTS; p++) begin
         for (int s = 0; s < `ARB_DEPTH; s++) begin
            if (entry_q[p][s] != `ARB_NO_CONN) begin
               empty = 1'b0;
            end
         end
      end
   end

   assign ctrl.all_empty = empty;

   // sequencer reloads only between rounds, matcher clears only inside one
   a_no_load_during_clr: assert property (
      @(posedge cur_state) disable iff (!arst_n)
      !(ctrl.load && buf_io.clr)
   );

endmodule

`default_nettype wire

// File: verilog/arb_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module arb_sequencer (
   input logic cur_state,
   input logic arst_n,
   input logic en,
   input arb_pkg::neuron_mask_t neuron_done,
   input logic drdy,
   output logic srdy,
   arb_ctrl_if.seq ctrl
);
   import arb_pkg::*;

   arb_state_t state_q;
   arb_state_t state_d;
   neuron_mask_t pending_q;
   neuron_mask_t done_in;
   port_idx_t bias_q;
   logic srdy_q;

   assign done_in = en ? neuron_done : '0; // capture only while enabled

   //////////////////////////////
   // state machine
   //////////////////////////////

   always_comb begin
      state_d = state_q;
      case (state_q)
         ARB_IDLE: begin
            if (|(pending_q | done_in)) begin
               state_d = ARB_SCAN;
            end
         end
         ARB_SCAN: state_d = ARB_MATCH; // load and start go out together
         ARB_MATCH: begin
            if (ctrl.match_done) begin
               state_d = ARB_XMIT;
            end
         end
         ARB_XMIT: begin
            if (drdy) begin
               state_d = ARB_ACK;
            end
         end
         ARB_ACK: begin
            if (!drdy) begin
               // more work if anything is pending or left in the buffers
               state_d = (|(pending_q | done_in) || !ctrl.all_empty) ? ARB_SCAN : ARB_IDLE;
            end
         end
         default: state_d = ARB_IDLE;
      endcase
   end

   always_ff @(posedge cur_state or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= ARB_IDLE;
         pending_q <= '0;
         bias_q <= '0;
         srdy_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (state_q == ARB_SCAN) begin
            pending_q <= '0; // everything pending is loaded now
         end else begin
            pending_q <= pending_q | done_in;
         end
         if (ctrl.match_done) begin
            bias_q <= bias_q + 1'b1; // rotate the first source
         end
         if (state_q == ARB_XMIT && drdy) begin
            srdy_q <= 1'b1;
         end else if (state_q == ARB_ACK && !drdy) begin
            srdy_q <= 1'b0;
         end
      end
   end

   //////////////////////////////
   // outputs
   //////////////////////////////

   assign ctrl.load = (state_q == ARB_SCAN);
   assign ctrl.load_mask = pending_q | done_in; // includes this cycle's done bits
   assign ctrl.match_start = (state_q == ARB_SCAN);
   assign ctrl.bias = bias_q;
   assign srdy = srdy_q;

   a_srdy_only_in_ack: assert property (
      @(posedge cur_state) disable iff (!arst_n)
      srdy |-> (state_q == ARB_ACK)
   );

endmodule

`default_nettype wire

// File: verilog/round_robin_matcher.sv
`timescale 1ns/1ps
`default_nettype none

`include "arb_macros.svh"

module round_robin_matcher (
   input logic cur_state,
   input logic arst_n,
   arb_ctrl_if.matcher ctrl,
   arb_buf_if.matcher buf_io,
   output arb_pkg::port_map_t port_dst
);
   import arb_pkg::*;

   logic busy_q;
   port_idx_t dst_cnt_q; // destination under search
   logic [`ARB_PORTS-1:0] locked_q; // indexed by source port number
   port_map_t work_q;
   port_map_t work_next;
   port_map_t port_dst_q;
   dest_t want;
   logic hit;
   port_idx_t hit_src;
   port_idx_t hit_slot;
   logic map_dup;

   assign want = dest_t'(dst_cnt_q);

   //////////////////////////////
   // search for one destination
   //////////////////////////////

   // sources from the bias onward, slots from each source's pointer onward
   always_comb begin : search
      port_idx_t src;
      port_idx_t slot;
      hit = 1'b0;
      hit_src = '0;
      hit_slot = '0;
      for (int i = 0; i < `ARB_PORTS; i++) begin
         src = port_idx_t'(ctrl.bias + i);
         for (int j = 0; j < `ARB_DEPTH; j++) begin
            slot = port_idx_t'(buf_io.ptrs[src] + j);
            if (!hit && !locked_q[src] && buf_io.entries[src][slot] == want) begin
               hit = 1'b1;
               hit_src = src;
               hit_slot = slot;
            end
         end
      end
   end

   always_comb begin
      work_next = work_q;
      if (hit) begin
         work_next[`ARB_DEST_W*(`ARB_PORTS-1-hit_src) +: `ARB_DEST_W] = want; // port 0 on top
      end
   end

   assign buf_io.clr = busy_q && hit;
   assign buf_io.clr_src = hit_src;
   assign buf_io.clr_slot = hit_slot;

   //////////////////////////////
   // round control
   //////////////////////////////

   always_ff @(posedge cur_state or negedge arst_n) begin
      if (!arst_n) begin
         busy_q <= 1'b0;
         dst_cnt_q <= '0;
         locked_q <= '0;
         work_q <= {`ARB_PORTS{`ARB_NO_CONN}};
         port_dst_q <= {`ARB_PORTS{`ARB_NO_CONN}};
      end else if (ctrl.match_start) begin
         busy_q <= 1'b1;
         dst_cnt_q <= '0;
         locked_q <= '0; // every source free again
         work_q <= {`ARB_PORTS{`ARB_NO_CONN}};
      end else if (busy_q) begin
         dst_cnt_q <= dst_cnt_q + 1'b1;
         work_q <= work_next;
         if (hit) begin
            locked_q[hit_src] <= 1'b1; // one destination per source
         end
         if (dst_cnt_q == port_idx_t'(`ARB_PORTS-1)) begin
            busy_q <= 1'b0;
            port_dst_q <= work_next; // last destination folded in
         end
      end
   end

   assign ctrl.match_done = busy_q && (dst_cnt_q == port_idx_t'(`ARB_PORTS-1));
   assign port_dst = port_dst_q;

   //////////////////////////////
   // map check
   //////////////////////////////

   always_comb begin
      map_dup = 1'b0;
      for (int a = 0; a < `ARB_PORTS; a++) begin
         for (int b = a + 1; b < `ARB_PORTS; b++) begin
            if (port_dst_q[`ARB_DEST_W*a +: `ARB_DEST_W] != `ARB_NO_CONN &&
                port_dst_q[`ARB_DEST_W*a +: `ARB_DEST_W] ==
                port_dst_q[`ARB_DEST_W*b +: `ARB_DEST_W]) begin
               map_dup = 1'b1;
            end
         end
      end
   end

   // locking across the eight steps must keep every destination unique
   a_map_unique: assert property (
      @(posedge cur_state) disable iff (!arst_n)
      !map_dup
   );

endmodule

`default_nettype wire

// File: verilog/spike_route_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "arb_macros.svh"

module spike_route_arbiter (
   input logic cur_state,
   input logic arst_n,
   input logic en,
   input logic [`ARB_PORTS-1:0] neuron_done,
   input logic [`ARB_PORTS*`ARB_DEPTH*`ARB_DEST_W-1:0] network,
   input logic drdy,
   output logic srdy,
   output logic [`ARB_PORTS*`ARB_DEST_W-1:0] port_dst
);

   arb_ctrl_if ctrl_if ();
   arb_buf_if buf_if ();

   //////////////////////////////
   // submodules
   //////////////////////////////

   dest_buffer_bank u_bank (
      .cur_state (cur_state),
      .arst_n (arst_n),
      .network (network),
      .ctrl (ctrl_if.bank),
      .buf_io (buf_if.bank)
   );

   arb_sequencer u_seq (
      .cur_state (cur_state),
      .arst_n (arst_n),
      .en (en),
      .neuron_done (neuron_done),
      .drdy (drdy),
      .srdy (srdy),
      .ctrl (ctrl_if.seq)
   );

   // buffer contents plus the sequencer's bias
   round_robin_matcher u_match (
      .cur_state (cur_state),
      .arst_n (arst_n),
      .ctrl (ctrl_if.matcher),
      .buf_io (buf_if.matcher),
      .port_dst (port_dst)
   );

endmodule

`default_nettype wire

// File: tests/tb_spike_route_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "arb_macros.svh"

module tb_spike_route_arbiter;

   localparam int CLK_PERIOD = 100;
   localparam int NET_W = `ARB_PORTS * `ARB_DEPTH * `ARB_DEST_W;
   localparam int N_TABLES = 16;
   localparam int WAIT_LIMIT = 40; // cycles allowed for one srdy edge
   localparam int WATCHDOG_CYCLES = (40 + N_TABLES * 48) * 20; // rounds times ~20 cycles

   typedef enum int {M_IDLE, M_SCAN, M_MATCH, M_XMIT, M_ACK} model_state_t;

   logic cur_state;
   logic arst_n;
   logic en;
   logic [`ARB_PORTS-1:0] neuron_done;
   logic [NET_W-1:0] network;
   logic drdy;
   logic srdy;
   logic [`ARB_PORTS*`ARB_DEST_W-1:0] port_dst;

   model_state_t m_state = M_IDLE;
   logic [7:0] m_pend;
   int m_bias;
   int m_cnt;
   logic [3:0] m_buf [8][8]; // [source][slot]
   int m_ptr [8];
   logic [31:0] exp_map;
   logic [31:0] rng = 32'h0f87_6ba0;

   spike_route_arbiter uut (
      .cur_state (cur_state),
      .arst_n (arst_n),
      .en (en),
      .neuron_done (neuron_done),
      .network (network),
      .drdy (drdy),
      .srdy (srdy),
      .port_dst (port_dst)
   );

   always #(CLK_PERIOD / 2) cur_state = ~cur_state;

   task automatic report_failure(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1, "stopping at first error");
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic bit map_has_dup(input logic [31:0] m);
      bit dup;
      dup = 1'b0;
      for (int a = 0; a < 8; a++) begin
         for (int b = a + 1; b < 8; b++) begin
            if (m[4*a +: 4] != `ARB_NO_CONN && m[4*a +: 4] == m[4*b +: 4]) dup = 1'b1;
         end
      end
      return dup;
   endfunction

   function automatic void set_slot(input int p, input int s, input logic [3:0] code);
      network[NET_W-1-(p*8+s)*4 -: 4] = code; // port 0 and slot 0 on top
   endfunction

   //////////////////////////////
   // reference model
   //////////////////////////////

   function automatic bit model_empty();
      bit empty;
      empty = 1'b1;
      for (int p = 0; p < 8; p++) begin
         for (int s = 0; s < 8; s++) begin
            if (m_buf[p][s] != `ARB_NO_CONN) empty = 1'b0;
         end
      end
      return empty;
   endfunction

   function automatic void model_load(input logic [7:0] mask);
      for (int p = 0; p < 8; p++) begin
         if (mask[7-p]) begin // msb is port 0
            for (int s = 0; s < 8; s++) m_buf[p][s] = network[NET_W-1-(p*8+s)*4 -: 4];
         end
      end
   endfunction

   // destinations in order, sources from the bias, slots from each pointer
   function automatic void model_round();
      logic [7:0] locked;
      logic [31:0] map;
      bit found;
      int s;
      int k;
      locked = '0;
      map = '1;
      for (int d = 0; d < 8; d++) begin
         found = 1'b0;
         for (int i = 0; i < 8; i++) begin
            s = (m_bias + i) % 8;
            for (int j = 0; j < 8; j++) begin
               k = (m_ptr[s] + j) % 8;
               if (!found && !locked[s] && m_buf[s][k] == 4'(d)) begin
                  found = 1'b1;
                  locked[s] = 1'b1;
                  map[4*(7-s) +: 4] = 4'(d);
                  m_buf[s][k] = `ARB_NO_CONN;
                  m_ptr[s] = (k + 1) % 8; // pointer moves past the grant
               end
            end
         end
      end
      exp_map = map;
      m_bias = (m_bias + 1) % 8;
   endfunction

   always @(posedge cur_state) begin : ref_model
      logic [7:0] done_in;
      bit load_now;
      if (!arst_n) begin
         m_state = M_IDLE;
         m_pend = '0;
         m_bias = 0;
         m_cnt = 0;
         exp_map = '1;
         for (int p = 0; p < 8; p++) begin
            m_ptr[p] = 0;
            for (int s = 0; s < 8; s++) m_buf[p][s] = `ARB_NO_CONN;
         end
      end else begin
         done_in = en ? neuron_done : 8'h00;
         load_now = (m_state == M_SCAN);
         case (m_state)
            M_IDLE: if (|(m_pend | done_in)) m_state = M_SCAN;
            M_SCAN: begin
               model_load(m_pend | done_in); // this cycle's done bits too
               model_round();
               m_cnt = 0;
               m_state = M_MATCH;
            end
            M_MATCH: begin
               m_cnt++;
               if (m_cnt == 8) m_state = M_XMIT; // one destination per cycle
            end
            M_XMIT: if (drdy) m_state = M_ACK;
            M_ACK: begin
               if (!drdy) m_state = (|(m_pend | done_in) || !model_empty()) ? M_SCAN : M_IDLE;
            end
            default: m_state = M_IDLE;
         endcase
         m_pend = load_now ? 8'h00 : (m_pend | done_in);
      end
   end

   //////////////////////////////
   // checks
   //////////////////////////////

   a_srdy_level: assert property (@(negedge cur_state) disable iff (!arst_n)
      srdy == (m_state == M_ACK))
      else report_failure($sformatf("FAIL srdy: expected %h, got %h", m_state == M_ACK, srdy));

   a_map_on_rise: assert property (@(negedge cur_state) disable iff (!arst_n)
      $rose(srdy) |-> port_dst == exp_map)
      else report_failure($sformatf("FAIL port_dst: expected %h, got %h", exp_map, port_dst));

   a_map_held: assert property (@(negedge cur_state) disable iff (!arst_n)
      srdy && $past(srdy) |-> $stable(port_dst))
      else report_failure($sformatf("FAIL port_dst: expected %h held, got %h", exp_map, port_dst));

   a_map_unique: assert property (@(negedge cur_state) disable iff (!arst_n)
      srdy |-> !map_has_dup(port_dst))
      else report_failure($sformatf("FAIL port_dst: repeated destination in %h", port_dst));

   //////////////////////////////
   // stimulus
   //////////////////////////////

   task automatic wait_srdy(input logic level);
      int n;
      n = 0;
      while (srdy !== level) begin
         @(negedge cur_state);
         n++;
         if (n > WAIT_LIMIT) begin
            report_failure($sformatf("srdy did not go to %0d within %0d cycles", level, WAIT_LIMIT));
         end
      end
   endtask

   task automatic pulse_done(input logic [7:0] mask);
      @(negedge cur_state);
      neuron_done = mask;
      @(negedge cur_state);
      neuron_done = 8'h00;
   endtask

   task automatic handshake(input int hold);
      @(negedge cur_state);
      drdy = 1'b1;
      wait_srdy(1'b1);
      repeat (hold) @(negedge cur_state); // back-pressure
      drdy = 1'b0;
      wait_srdy(1'b0);
   endtask

   task automatic drain_rounds(input int hold, input bit random_hold);
      int h;
      do begin
         rng = xorshift32(rng);
         h = random_hold ? int'(rng[1:0]) : hold;
         handshake(h);
      end while (m_state != M_IDLE);
   endtask

   initial begin : watchdog
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      report_failure("simulation ran past the watchdog limit");
   end

   initial begin
      int c;
      int h;
      logic [7:0] mask;
      cur_state = 1'b0;
      arst_n = 1'b0;
      en = 1'b0;
      neuron_done = '0;
      network = '1;
      drdy = 1'b0;
      repeat (8) @(negedge cur_state);
      assert (srdy === 1'b0 && port_dst === 32'hFFFF_FFFF) else report_failure(
         $sformatf("FAIL port_dst/srdy: expected ffffffff/0, got %h/%h", port_dst, srdy));
      arst_n = 1'b1;

      drdy = 1'b1; // done bits ignored while en is low
      pulse_done(8'hFF);
      repeat (20) @(negedge cur_state);
      drdy = 1'b0;

      en = 1'b1; // one source, one destination
      set_slot(2, 0, 4'h5);
      pulse_done(8'h20);
      drain_rounds(0, 1'b0);
      assert (port_dst === 32'hFF5F_FFFF) else report_failure(
         $sformatf("FAIL port_dst: expected ff5fffff, got %h", port_dst));
      drdy = 1'b1;
      repeat (20) @(negedge cur_state);
      drdy = 1'b0;

      network = '1; // ports 1 and 4 fight for destination 3
      for (int s = 0; s < 3; s++) begin
         set_slot(1, s, 4'h3);
         set_slot(4, s, 4'h3);
      end
      pulse_done(8'h48);
      drain_rounds(1, 1'b0);

      // port c takes the head entry of port h and h still gets a later one
      network = '1;
      c = m_bias;
      h = (m_bias + 1) % 8;
      set_slot(c, m_ptr[c], 4'h2);
      set_slot(h, m_ptr[h], 4'h2);
      set_slot(h, (m_ptr[h] + 1) % 8, 4'h5);
      pulse_done((8'h80 >> c) | (8'h80 >> h));
      handshake(0);
      assert (port_dst[4*(7-h) +: 4] === 4'h5 && port_dst[4*(7-c) +: 4] === 4'h2)
         else report_failure($sformatf("FAIL port_dst: expected port %0d = 5, port %0d = 2, got %h",
            h, c, port_dst));
      if (m_state != M_IDLE) drain_rounds(0, 1'b0);

      network = '1; // drdy held high for several cycles per round
      for (int p = 0; p < 8; p += 3) begin
         for (int s = 0; s < 4; s++) set_slot(p, s, 4'((p + s) % 8));
      end
      pulse_done(8'hFF);
      drain_rounds(6, 1'b0);

      for (int t = 0; t < N_TABLES; t++) begin
         for (int p = 0; p < 8; p++) begin
            for (int s = 0; s < 8; s++) begin
               rng = xorshift32(rng);
               set_slot(p, s, rng[3] ? `ARB_NO_CONN : {1'b0, rng[2:0]});
            end
         end
         rng = xorshift32(rng);
         mask = (rng[7:0] == 8'h00) ? 8'h01 : rng[7:0];
         pulse_done(mask);
         repeat (3) @(negedge cur_state);
         en = rng[16]; // mid-round pulse that en sometimes masks
         neuron_done = rng[15:8];
         @(negedge cur_state);
         neuron_done = 8'h00;
         en = 1'b1;
         drain_rounds(0, 1'b1);
      end

      $display("Test completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
verilog/arb_pkg.sv
verilog/arb_ctrl_if.sv
verilog/arb_buf_if.sv
verilog/dest_buffer_bank.sv
verilog/arb_sequencer.sv
verilog/round_robin_matcher.sv
verilog/spike_route_arbiter.sv
tests/tb_spike_route_arbiter.sv

// File: run.sh
#!/bin/sh
# build and run the spike route arbiter testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tb_spike_route_arbiter \
   -f flist.f -Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation returned status $status"
   exit 1
fi

if grep -q "Test completed successfully" sim.log; then
   exit 0
fi
echo "pass message not found in sim.log"
exit 1
